// File: proc_inst_pkg.sv
// ----------------------------------------
// instruction encoding for the core
// opcodes, field positions, csr numbers
// ----------------------------------------

package proc_inst_pkg;

  // opcode lives in bits 31..26, other values act as no-op
  typedef enum logic [5:0] {
    OP_ADDU  = 6'h01,
    OP_SUBU  = 6'h02,
    OP_AND   = 6'h03,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_LUI   = 6'h0f,
    OP_MFX   = 6'h10,
    OP_MTX   = 6'h11,
    OP_CSRR  = 6'h12,
    OP_CSRW  = 6'h13,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } proc_opcode_e;

  // register field positions, each 5 bits wide
  localparam int RS_LSB = 21;
  localparam int RT_LSB = 16;
  localparam int RD_LSB = 11;

  // csr numbers, carried in the immediate
  localparam logic [15:0] CSR_NUMCORES = 16'h0fc1;
  localparam logic [15:0] CSR_COREID   = 16'h0f14;
  localparam logic [15:0] CSR_STATS_EN = 16'h07c1;

  // alu functions
  localparam logic [1:0] ALU_ADD  = 2'd0;
  localparam logic [1:0] ALU_SUB  = 2'd1;
  localparam logic [1:0] ALU_AND  = 2'd2;
  localparam logic [1:0] ALU_PASS = 2'd3;

  // operand and writeback selects
  localparam logic [1:0] BYP_RF   = 2'd0;
  localparam logic [1:0] BYP_X    = 2'd1;
  localparam logic [1:0] BYP_W    = 2'd2;
  localparam logic [1:0] OP1_REG  = 2'd0;
  localparam logic [1:0] OP1_IMM  = 2'd1;
  localparam logic [1:0] OP1_LUI  = 2'd2;
  localparam logic [1:0] OP1_MNGR = 2'd3;
  localparam logic [1:0] WB_ALU   = 2'd0;
  localparam logic [1:0] WB_MEM   = 2'd1;
  localparam logic [1:0] WB_CSR   = 2'd2;

endpackage

// File: proc_mem_pkg.sv
// ----------------------------------------
// memory port definitions
// request type and bus widths
// ----------------------------------------

package proc_mem_pkg;

  // address and data widths of both ports
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // request type on the data port
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } proc_memreq_type_e;

endpackage

// File: proc_regfile.sv
// ----------------------------------------
// register file, 2 read ports, 1 write
// ----------------------------------------

`timescale 1ns/1ps

module proc_regfile (
  input  logic        clk,
  input  logic [4:0]  raddr0,
  output logic [31:0] rdata0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata1,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [0:31];

  // write port, r0 stays untouched
  always_ff @(posedge clk)
  begin
    if (wen && (waddr != 5'd0))
    begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, r0 is hardwired zero
  // the W bypass in the datapath covers same-cycle writes
  always_comb
  begin
    rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
    rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  end

endmodule

// File: proc_csr.sv
// ----------------------------------------
// control/status registers
// stats enable plus core id and count
// ----------------------------------------

`timescale 1ns/1ps

module proc_csr #(
  parameter int p_num_cores = 1,
  parameter int p_core_id   = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] rd_addr,
  output logic [31:0] rd_data,
  input  logic        wen,
  input  logic [15:0] wr_addr,
  input  logic [31:0] wr_data,
  output logic        stats_en
);

  import proc_inst_pkg::*;

  // only stats_en is writable
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      stats_en <= 1'b0;
    else if (wen && (wr_addr == CSR_STATS_EN))
      stats_en <= wr_data[0];
  end

  // read mux used by csrr in D
  always_comb
  begin
    case (rd_addr)
      CSR_NUMCORES: rd_data = 32'(p_num_cores);
      CSR_COREID:   rd_data = 32'(p_core_id);
      CSR_STATS_EN: rd_data = {31'd0, stats_en};
      default:      rd_data = 32'd0;
    endcase
  end

  // csrw coming out of W must name the one writable csr
  a_csr_write_target: assert property (@(posedge clk) disable iff (!rst_n)
    wen |-> (wr_addr == CSR_STATS_EN));

endmodule

// File: proc_ctrl.sv
// ----------------------------------------
// pipeline control for the 4-stage core
// decode, stalls, squash, bypass selects
// ----------------------------------------

`timescale 1ns/1ps

module proc_ctrl (
  input  logic        clk,
  input  logic        rst_n,
  output logic        imemreq_val,
  input  logic        imemreq_rdy,
  input  logic        imemresp_val,
  output logic        imemresp_rdy,
  output logic        dmemreq_val,
  input  logic        dmemreq_rdy,
  output proc_mem_pkg::proc_memreq_type_e dmemreq_type,
  input  logic        dmemresp_val,
  output logic        dmemresp_rdy,
  input  logic        from_mngr_val,
  output logic        from_mngr_rdy,
  output logic        to_mngr_val,
  input  logic        to_mngr_rdy,
  output logic        pc_sel_F,
  output logic        reg_en_F,
  output logic        reg_en_D,
  output logic        reg_en_X,
  output logic        reg_en_W,
  output logic [1:0]  op0_byp_sel_D,
  output logic [1:0]  op1_byp_sel_D,
  output logic [1:0]  op1_sel_D,
  output logic [1:0]  alu_fn_X,
  output logic [1:0]  wb_sel_X,
  output logic [4:0]  rf_waddr_W,
  output logic        rf_wen_W,
  output logic        csr_wen_W,
  output logic [15:0] csr_addr_D,
  output logic [15:0] csr_waddr_W,
  input  logic [31:0] inst_D,
  input  logic        br_cond_ne_X
);

  import proc_inst_pkg::*;
  import proc_mem_pkg::*;

  // stage state
  logic started, req_out, val_D, val_X, val_W, dreq_sent_X;
  logic [1:0] drop_cnt;
  // X and W control fields
  logic rf_wen_X, lw_X, sw_X, bne_X, mtx_X, csrw_X, csrw_W;
  logic [4:0] rf_waddr_X;
  logic [15:0] csr_waddr_X;
  // D decode
  proc_opcode_e opcode_D;
  logic [4:0] rs_D, rt_D, rd_D, d_waddr;
  logic d_rs_en, d_rt_en, d_wen, d_lw, d_sw, d_bne, d_mfx, d_mtx, d_csrr, d_csrw;
  logic [1:0] d_alu_fn, d_wb_sel;
  // handshake and stall terms
  logic req_fire, resp_fire, resp_drop, resp_take, squash, squash_inc;
  logic stall_X, x_ready, load_use, csr_hz, stall_D, go_D;

  // ----------------------------------------
  // decode in D
  // ----------------------------------------
  assign opcode_D   = proc_opcode_e'(inst_D[31:26]);
  assign rs_D       = inst_D[RS_LSB +: 5];
  assign rt_D       = inst_D[RT_LSB +: 5];
  assign rd_D       = inst_D[RD_LSB +: 5];
  assign csr_addr_D = inst_D[15:0];

  always_comb
  begin
    {d_rs_en, d_rt_en, d_wen, d_lw, d_sw, d_bne} = '0;
    {d_mfx, d_mtx, d_csrr, d_csrw} = '0;
    d_waddr   = rt_D;
    d_alu_fn  = ALU_ADD;
    op1_sel_D = OP1_REG;
    d_wb_sel  = WB_ALU;
    case (opcode_D)
      OP_ADDU, OP_SUBU, OP_AND:
      begin
        {d_rs_en, d_rt_en, d_wen} = 3'b111;
        d_waddr  = rd_D;
        d_alu_fn = (opcode_D == OP_SUBU) ? ALU_SUB :
                   (opcode_D == OP_AND)  ? ALU_AND : ALU_ADD;
      end
      OP_ADDIU:
      begin
        {d_rs_en, d_wen} = 2'b11;
        op1_sel_D = OP1_IMM;
      end
      OP_LUI:
      begin
        d_wen     = 1'b1;
        op1_sel_D = OP1_LUI;
        d_alu_fn  = ALU_PASS;
      end
      OP_LW:
      begin
        {d_rs_en, d_wen, d_lw} = 3'b111;
        op1_sel_D = OP1_IMM;
        d_wb_sel  = WB_MEM;
      end
      OP_SW:
      begin
        {d_rs_en, d_rt_en, d_sw} = 3'b111;
        op1_sel_D = OP1_IMM;
      end
      OP_BNE: {d_rs_en, d_rt_en, d_bne} = 3'b111;
      OP_MFX:
      begin
        {d_wen, d_mfx} = 2'b11;
        op1_sel_D = OP1_MNGR;
        d_alu_fn  = ALU_PASS;
      end
      OP_MTX: {d_rt_en, d_mtx} = 2'b11;
      OP_CSRR:
      begin
        {d_wen, d_csrr} = 2'b11;
        d_wb_sel = WB_CSR;
      end
      OP_CSRW:
      begin
        {d_rt_en, d_csrw} = 2'b11;
        d_alu_fn = ALU_PASS;
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // stalls, squash and bypass
  // ----------------------------------------
  // X waits on the data port or on the manager
  assign stall_X = val_X && (((lw_X || sw_X) && !(dreq_sent_X && dmemresp_val)) ||
                             (mtx_X && !to_mngr_rdy));
  assign x_ready = !val_X || !stall_X;
  assign squash  = val_X && bne_X && br_cond_ne_X;

  // load value only exists once lw reaches W
  assign load_use = val_X && lw_X && (rf_waddr_X != 5'd0) &&
                    ((d_rs_en && rs_D == rf_waddr_X) || (d_rt_en && rt_D == rf_waddr_X));
  assign csr_hz   = d_csrr && ((val_X && csrw_X) || (val_W && csrw_W));
  assign stall_D  = load_use || csr_hz || (d_mfx && !from_mngr_val);
  assign go_D     = val_D && !squash && !stall_D && x_ready;

  always_comb
  begin
    op0_byp_sel_D = BYP_RF;
    op1_byp_sel_D = BYP_RF;
    if (val_W && rf_wen_W && rf_waddr_W != 5'd0 && rf_waddr_W == rs_D)
      op0_byp_sel_D = BYP_W;
    if (val_X && rf_wen_X && rf_waddr_X != 5'd0 && rf_waddr_X == rs_D)
      op0_byp_sel_D = BYP_X;
    if (val_W && rf_wen_W && rf_waddr_W != 5'd0 && rf_waddr_W == rt_D)
      op1_byp_sel_D = BYP_W;
    if (val_X && rf_wen_X && rf_waddr_X != 5'd0 && rf_waddr_X == rt_D)
      op1_byp_sel_D = BYP_X;
  end

  // ----------------------------------------
  // ports and stage enables
  // ----------------------------------------
  assign imemreq_val  = started && !req_out;
  assign req_fire     = imemreq_val && imemreq_rdy;
  assign resp_drop    = (drop_cnt != 2'd0);
  assign imemresp_rdy = resp_drop || (req_out && (!val_D || go_D || squash));
  assign resp_fire    = imemresp_val && imemresp_rdy;
  assign resp_take    = resp_fire && !resp_drop;
  // squashed fetch whose response is still on its way
  assign squash_inc   = squash && ((req_out && !resp_take) || req_fire);

  assign from_mngr_rdy = val_D && d_mfx && !squash && x_ready;
  assign dmemreq_val   = val_X && (lw_X || sw_X) && !dreq_sent_X;
  assign dmemreq_type  = sw_X ? MEM_WRITE : MEM_READ;
  assign dmemresp_rdy  = val_X && (lw_X || sw_X) && dreq_sent_X;
  assign to_mngr_val   = val_X && mtx_X;

  assign pc_sel_F = squash;
  assign reg_en_F = resp_take || squash;
  assign reg_en_D = resp_take && !squash;
  assign reg_en_X = x_ready;
  assign reg_en_W = val_X && !stall_X;
  assign csr_wen_W = val_W && csrw_W;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      {started, req_out, val_D, val_X, val_W, dreq_sent_X} <= '0;
      {rf_wen_X, lw_X, sw_X, bne_X, mtx_X, csrw_X, rf_wen_W, csrw_W} <= '0;
      drop_cnt <= 2'd0;
      {rf_waddr_X, rf_waddr_W} <= '0;
      {csr_waddr_X, csr_waddr_W} <= '0;
      alu_fn_X <= ALU_ADD;
      wb_sel_X <= WB_ALU;
    end
    else
    begin
      started  <= 1'b1;
      req_out  <= squash ? 1'b0 : (req_fire || (req_out && !resp_take));
      drop_cnt <= drop_cnt + {1'b0, squash_inc} - {1'b0, resp_fire && resp_drop};
      val_D    <= !squash && (reg_en_D || (val_D && !go_D));
      if (dmemreq_val && dmemreq_rdy)
        dreq_sent_X <= 1'b1;
      else if (!stall_X)
        dreq_sent_X <= 1'b0;
      if (reg_en_X)
      begin
        val_X       <= go_D;
        rf_wen_X    <= d_wen;
        rf_waddr_X  <= d_waddr;
        {lw_X, sw_X, bne_X, mtx_X, csrw_X} <= {d_lw, d_sw, d_bne, d_mtx, d_csrw};
        alu_fn_X    <= d_alu_fn;
        wb_sel_X    <= d_wb_sel;
        csr_waddr_X <= csr_addr_D;
      end
      val_W <= reg_en_W;
      if (reg_en_W)
      begin
        rf_wen_W    <= rf_wen_X;
        rf_waddr_W  <= rf_waddr_X;
        csrw_W      <= csrw_X;
        csr_waddr_W <= csr_waddr_X;
      end
    end
  end

  // enables never act on an unknown valid
  a_en_known_f: assert property (@(posedge clk) disable iff (!rst_n)
    reg_en_F |-> !$isunknown(imemresp_val));
  a_en_known_x: assert property (@(posedge clk) disable iff (!rst_n)
    reg_en_X |-> !$isunknown(go_D));

  // only one fetch is ever in flight
  // a wrap below zero would show up as a count above one
  a_drop_floor: assert property (@(posedge clk) disable iff (!rst_n)
    drop_cnt <= 2'd1);

endmodule

// File: proc_dpath.sv
// ----------------------------------------
// datapath: pc, pipeline registers, alu,
// branch compare and writeback mux
// ----------------------------------------

`timescale 1ns/1ps

module proc_dpath (
  input  logic        clk,
  input  logic        rst_n,
  output logic [proc_mem_pkg::ADDR_W-1:0] imemreq_addr,
  input  logic [proc_mem_pkg::DATA_W-1:0] imemresp_data,
  output logic [proc_mem_pkg::ADDR_W-1:0] dmemreq_addr,
  output logic [proc_mem_pkg::DATA_W-1:0] dmemreq_data,
  input  logic [proc_mem_pkg::DATA_W-1:0] dmemresp_data,
  input  logic [proc_mem_pkg::DATA_W-1:0] from_mngr_data,
  output logic [proc_mem_pkg::DATA_W-1:0] to_mngr_data,
  output logic [4:0]  rf_raddr0,
  output logic [4:0]  rf_raddr1,
  input  logic [31:0] rf_rdata0,
  input  logic [31:0] rf_rdata1,
  output logic [31:0] rf_wdata,
  input  logic [31:0] csr_rd_data,
  output logic [31:0] csr_wr_data,
  input  logic        pc_sel_F,
  input  logic        reg_en_F,
  input  logic        reg_en_D,
  input  logic        reg_en_X,
  input  logic        reg_en_W,
  input  logic [1:0]  op0_byp_sel_D,
  input  logic [1:0]  op1_byp_sel_D,
  input  logic [1:0]  op1_sel_D,
  input  logic [1:0]  alu_fn_X,
  input  logic [1:0]  wb_sel_X,
  output logic [31:0] inst_D,
  output logic        br_cond_ne_X
);

  import proc_inst_pkg::*;
  import proc_mem_pkg::*;

  logic [ADDR_W-1:0] pc_F, pc_D, br_target_D, br_target_X;
  logic [DATA_W-1:0] imm_D, op0_D, rt_val_D, op1_D;
  logic [DATA_W-1:0] op0_X, op1_X, sdata_X, csr_X, alu_X, result_X, result_W;

  // ----------------------------------------
  // F and D
  // ----------------------------------------
  // pc_F is the address of the pending or next fetch
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pc_F <= 32'h0000_0200;
    else if (reg_en_F)
      pc_F <= pc_sel_F ? br_target_X : pc_F + 32'd4;
  end
  assign imemreq_addr = pc_F;

  always_ff @(posedge clk)
  begin
    if (reg_en_D)
    begin
      inst_D <= imemresp_data;
      pc_D   <= pc_F;
    end
  end

  assign rf_raddr0   = inst_D[RS_LSB +: 5];
  assign rf_raddr1   = inst_D[RT_LSB +: 5];
  assign imm_D       = {{16{inst_D[15]}}, inst_D[15:0]};
  // word offset relative to pc+4
  assign br_target_D = pc_D + 32'd4 + {imm_D[29:0], 2'b00};

  // operand bypass, X wins over W
  always_comb
  begin
    case (op0_byp_sel_D)
      BYP_X:   op0_D = result_X;
      BYP_W:   op0_D = result_W;
      default: op0_D = rf_rdata0;
    endcase
    case (op1_byp_sel_D)
      BYP_X:   rt_val_D = result_X;
      BYP_W:   rt_val_D = result_W;
      default: rt_val_D = rf_rdata1;
    endcase
    case (op1_sel_D)
      OP1_IMM:  op1_D = imm_D;
      OP1_LUI:  op1_D = {inst_D[15:0], 16'd0};
      OP1_MNGR: op1_D = from_mngr_data;
      default:  op1_D = rt_val_D;
    endcase
  end

  // ----------------------------------------
  // X and W
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reg_en_X)
    begin
      op0_X       <= op0_D;
      op1_X       <= op1_D;
      sdata_X     <= rt_val_D;
      csr_X       <= csr_rd_data;
      br_target_X <= br_target_D;
    end
  end

  always_comb
  begin
    case (alu_fn_X)
      ALU_SUB:  alu_X = op0_X - op1_X;
      ALU_AND:  alu_X = op0_X & op1_X;
      ALU_PASS: alu_X = op1_X;
      default:  alu_X = op0_X + op1_X;
    endcase
    case (wb_sel_X)
      WB_MEM:  result_X = dmemresp_data;
      WB_CSR:  result_X = csr_X;
      default: result_X = alu_X;
    endcase
  end

  // bne compares both register operands
  assign br_cond_ne_X = (op0_X != op1_X);
  assign dmemreq_addr = alu_X;
  assign dmemreq_data = sdata_X;
  assign to_mngr_data = sdata_X;

  always_ff @(posedge clk)
  begin
    if (reg_en_W)
      result_W <= result_X;
  end

  assign rf_wdata    = result_W;
  assign csr_wr_data = result_W;

endmodule

// File: proc_pipelined.sv
// ----------------------------------------
// 4-stage pipelined core, top level
// ----------------------------------------

`timescale 1ns/1ps

module proc_pipelined #(
  parameter int p_num_cores = 1,
  parameter int p_core_id   = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic        imemreq_val,
  input  logic        imemreq_rdy,
  output logic [proc_mem_pkg::ADDR_W-1:0] imemreq_addr,
  input  logic        imemresp_val,
  output logic        imemresp_rdy,
  input  logic [proc_mem_pkg::DATA_W-1:0] imemresp_data,
  output logic        dmemreq_val,
  input  logic        dmemreq_rdy,
  output proc_mem_pkg::proc_memreq_type_e dmemreq_type,
  output logic [proc_mem_pkg::ADDR_W-1:0] dmemreq_addr,
  output logic [proc_mem_pkg::DATA_W-1:0] dmemreq_data,
  input  logic        dmemresp_val,
  output logic        dmemresp_rdy,
  input  logic [proc_mem_pkg::DATA_W-1:0] dmemresp_data,
  input  logic        from_mngr_val,
  output logic        from_mngr_rdy,
  input  logic [proc_mem_pkg::DATA_W-1:0] from_mngr_data,
  output logic        to_mngr_val,
  input  logic        to_mngr_rdy,
  output logic [proc_mem_pkg::DATA_W-1:0] to_mngr_data,
  output logic        stats_en
);

  // ctrl to dpath
  logic        pc_sel_F, reg_en_F, reg_en_D, reg_en_X, reg_en_W;
  logic [1:0]  op0_byp_sel_D, op1_byp_sel_D, op1_sel_D, alu_fn_X, wb_sel_X;
  // register file and csr wiring
  logic [4:0]  rf_raddr0, rf_raddr1, rf_waddr_W;
  logic [31:0] rf_rdata0, rf_rdata1, rf_wdata;
  logic        rf_wen_W, csr_wen_W;
  logic [15:0] csr_addr_D, csr_waddr_W;
  logic [31:0] csr_rd_data, csr_wr_data;
  // dpath status
  logic [31:0] inst_D;
  logic        br_cond_ne_X;

  // all ctrl and dpath ports share their names with these nets
  proc_ctrl ctrl (.*);

  proc_dpath dpath (.*);

  proc_regfile rf (
    .clk    (clk),
    .raddr0 (rf_raddr0),
    .rdata0 (rf_rdata0),
    .raddr1 (rf_raddr1),
    .rdata1 (rf_rdata1),
    .wen    (rf_wen_W),
    .waddr  (rf_waddr_W),
    .wdata  (rf_wdata)
  );

  proc_csr #(
    .p_num_cores (p_num_cores),
    .p_core_id   (p_core_id)
  ) csr (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr  (csr_addr_D),
    .rd_data  (csr_rd_data),
    .wen      (csr_wen_W),
    .wr_addr  (csr_waddr_W),
    .wr_data  (csr_wr_data),
    .stats_en (stats_en)
  );

endmodule

// File: tb_proc.sv
// ----------------------------------------
// testbench for the pipelined core
// rom, data memory, manager streams, checks
// ----------------------------------------

`timescale 1ns/1ps

module tb_proc;

  import proc_inst_pkg::*;
  import proc_mem_pkg::*;

  localparam int num_rows      = 12;
  localparam int words_per_row = 6;
  localparam int num_cores     = 4;
  localparam int core_id       = 2;
  localparam int rom_words     = 20;
  localparam logic [31:0] rom_base  = 32'h0000_0200;
  localparam logic [31:0] data_addr = 32'h0000_0100;
  localparam logic [15:0] lui_imm   = 16'h1234;
  localparam logic [15:0] addiu_imm = 16'h8765;
  // 400 cycles per row plus reset and the closing idle window
  localparam int timeout_cycles = 400 * num_rows + 128;

  // each row holds {stats_en, a, b}
  // stats_en equals bit 0 of a & b
  localparam logic [64:0] test_rows [num_rows] = '{
    {1'b1, 32'h0000_0005, 32'h0000_0003},
    {1'b0, 32'h0000_0010, 32'h0000_0020},
    {1'b1, 32'hffff_ffff, 32'h0000_0001},
    {1'b0, 32'h8000_0000, 32'h8000_0000},
    {1'b1, 32'h1234_5679, 32'h0fed_cba1},
    {1'b0, 32'h0000_0000, 32'hdead_beef},
    {1'b1, 32'h7fff_ffff, 32'hffff_ffff},
    {1'b0, 32'h0000_0064, 32'h0000_00c8},
    {1'b1, 32'hcafe_f00d, 32'h0000_0003},
    {1'b1, 32'h0000_0001, 32'h0000_0001},
    {1'b0, 32'ha5a5_a5a5, 32'h5a5a_5a5a},
    {1'b1, 32'h0000_0003, 32'h0000_0007}
  };

  logic        clk, rst_n;
  logic        imemreq_val, imemreq_rdy, imemresp_val, imemresp_rdy;
  logic [31:0] imemreq_addr, imemresp_data;
  logic        dmemreq_val, dmemreq_rdy, dmemresp_val, dmemresp_rdy;
  logic [31:0] dmemreq_addr, dmemreq_data, dmemresp_data;
  proc_memreq_type_e dmemreq_type;
  logic        from_mngr_val, from_mngr_rdy, to_mngr_val, to_mngr_rdy;
  logic [31:0] from_mngr_data, to_mngr_data;
  logic        stats_en;

  // memory models and manager streams
  logic [31:0] rom [rom_words];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] iresp_q [$];
  logic [31:0] dresp_q [$];
  logic [31:0] mngr_src_q [$];
  logic [31:0] expect_q [$];
  logic [31:0] imemresp_data_next;
  logic [31:0] lfsr;
  logic        imem_taken, dmem_taken, mngr_taken, pick;
  int          err_cnt, recv_cnt, dreq_cnt, cycle_cnt, row_idx, settle;

  proc_pipelined #(
    .p_num_cores (num_cores),
    .p_core_id   (core_id)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .imemreq_val    (imemreq_val),
    .imemreq_rdy    (imemreq_rdy),
    .imemreq_addr   (imemreq_addr),
    .imemresp_val   (imemresp_val),
    .imemresp_rdy   (imemresp_rdy),
    .imemresp_data  (imemresp_data),
    .dmemreq_val    (dmemreq_val),
    .dmemreq_rdy    (dmemreq_rdy),
    .dmemreq_type   (dmemreq_type),
    .dmemreq_addr   (dmemreq_addr),
    .dmemreq_data   (dmemreq_data),
    .dmemresp_val   (dmemresp_val),
    .dmemresp_rdy   (dmemresp_rdy),
    .dmemresp_data  (dmemresp_data),
    .from_mngr_val  (from_mngr_val),
    .from_mngr_rdy  (from_mngr_rdy),
    .from_mngr_data (from_mngr_data),
    .to_mngr_val    (to_mngr_val),
    .to_mngr_rdy    (to_mngr_rdy),
    .to_mngr_data   (to_mngr_data),
    .stats_en       (stats_en)
  );

  always #20 clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  // high about three cycles in four
  task automatic draw_likely(output logic b);
    logic b0, b1;
    draw_bit(b0);
    draw_bit(b1);
    b = b0 | b1;
  endtask

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] enc_reg(input proc_opcode_e op,
                                          input logic [4:0] rs, rt, rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [31:0] enc_imm(input proc_opcode_e op,
                                          input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_counts();
    $display("words received %0d of %0d, errors %0d", recv_cnt,
             num_rows * words_per_row, err_cnt);
  endtask

  // looping program at 0x200
  task automatic load_program();
    rom[0]  = enc_imm(OP_MFX,   5'd0, 5'd1, 16'd0);
    rom[1]  = enc_imm(OP_MFX,   5'd0, 5'd2, 16'd0);
    rom[2]  = enc_reg(OP_ADDU,  5'd1, 5'd2, 5'd3);
    // sum used right away through the X bypass
    rom[3]  = enc_imm(OP_MTX,   5'd0, 5'd3, 16'd0);
    rom[4]  = enc_imm(OP_SW,    5'd0, 5'd3, data_addr[15:0]);
    rom[5]  = enc_imm(OP_LW,    5'd0, 5'd5, data_addr[15:0]);
    // load-use stall
    rom[6]  = enc_imm(OP_MTX,   5'd0, 5'd5, 16'd0);
    rom[7]  = enc_reg(OP_SUBU,  5'd1, 5'd2, 5'd4);
    rom[8]  = enc_imm(OP_MTX,   5'd0, 5'd4, 16'd0);
    rom[9]  = enc_reg(OP_AND,   5'd1, 5'd2, 5'd6);
    rom[10] = enc_imm(OP_MTX,   5'd0, 5'd6, 16'd0);
    rom[11] = enc_imm(OP_LUI,   5'd0, 5'd7, lui_imm);
    rom[12] = enc_imm(OP_ADDIU, 5'd7, 5'd7, addiu_imm);
    rom[13] = enc_imm(OP_MTX,   5'd0, 5'd7, 16'd0);
    rom[14] = enc_imm(OP_CSRR,  5'd0, 5'd8, CSR_COREID);
    rom[15] = enc_imm(OP_MTX,   5'd0, 5'd8, 16'd0);
    rom[16] = enc_imm(OP_CSRW,  5'd0, 5'd6, CSR_STATS_EN);
    // r7 is never zero so this goes back 18 words to 0x200
    rom[17] = enc_imm(OP_BNE,   5'd7, 5'd0, 16'hffee);
    // wrong path that must never reach the manager
    rom[18] = enc_imm(OP_MTX,   5'd0, 5'd1, 16'd0);
    rom[19] = enc_imm(OP_MTX,   5'd0, 5'd1, 16'd0);
  endtask

  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    logic [31:0] idx;
    idx = (addr - rom_base) >> 2;
    if (addr[1:0] == 2'b00 && addr >= rom_base && idx < rom_words)
      data = rom[idx[4:0]];
    else
    begin
      $display("instruction fetch outside the program at address %h", addr);
      err_cnt++;
      data = 32'hfc00_0000;
    end
  endtask

  // even requests store a+b and odd ones load it back
  task automatic serve_data_req();
    int row;
    proc_memreq_type_e exp_type;
    row = dreq_cnt / 2;
    exp_type = (dreq_cnt % 2 == 0) ? MEM_WRITE : MEM_READ;
    if (row >= num_rows)
    begin
      $display("data request issued after the last table row");
      err_cnt++;
    end
    else
    begin
      check_value("dmemreq_type", 32'(dmemreq_type), 32'(exp_type));
      check_value("dmemreq_addr", dmemreq_addr, data_addr);
      if (exp_type == MEM_WRITE)
        check_value("dmemreq_data", dmemreq_data,
                    test_rows[row][63:32] + test_rows[row][31:0]);
    end
    if (dmemreq_type == MEM_WRITE)
    begin
      dmem[dmemreq_addr] = dmemreq_data;
      dresp_q.push_back(32'd0);
    end
    else if (dmem.exists(dmemreq_addr))
      dresp_q.push_back(dmem[dmemreq_addr]);
    else
      // unwritten words read back as the inverted address
      dresp_q.push_back(~dmemreq_addr);
    dreq_cnt++;
  endtask

  task automatic take_output();
    int row;
    logic exp_stats;
    row = recv_cnt / words_per_row;
    if (row > num_rows)
      row = num_rows;
    // stats_en still holds the previous row's csrw
    exp_stats = (row == 0) ? 1'b0 : test_rows[row - 1][64];
    if (expect_q.size() == 0)
    begin
      $display("core sent word %h when no word was expected", to_mngr_data);
      err_cnt++;
    end
    else
      check_value("to_mngr_data", to_mngr_data, expect_q.pop_front());
    check_value("stats_en", 32'(stats_en), 32'(exp_stats));
    recv_cnt++;
  endtask

  task automatic queue_row(input int r);
    logic [31:0] a, b;
    a = test_rows[r][63:32];
    b = test_rows[r][31:0];
    mngr_src_q.push_back(a);
    mngr_src_q.push_back(b);
    // mtx words in program order
    expect_q.push_back(a + b);
    expect_q.push_back(a + b);
    expect_q.push_back(a - b);
    expect_q.push_back(a & b);
    expect_q.push_back({lui_imm, 16'd0} + sext16(addiu_imm));
    expect_q.push_back(32'(core_id));
  endtask

  // ----------------------------------------
  // port models driven on the falling edge
  // ----------------------------------------
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      // responses taken at the last rising edge go away
      if (imem_taken)
        imemresp_val = 1'b0;
      if (dmem_taken)
        dmemresp_val = 1'b0;
      if (mngr_taken)
        from_mngr_val = 1'b0;
      {imem_taken, dmem_taken, mngr_taken} = 3'b000;
      draw_likely(imemreq_rdy);
      draw_likely(dmemreq_rdy);
      draw_likely(to_mngr_rdy);
      draw_likely(pick);
      if (!imemresp_val && iresp_q.size() > 0 && pick)
      begin
        imemresp_val  = 1'b1;
        imemresp_data = iresp_q[0];
      end
      draw_likely(pick);
      if (!dmemresp_val && dresp_q.size() > 0 && pick)
      begin
        dmemresp_val  = 1'b1;
        dmemresp_data = dresp_q[0];
      end
      draw_likely(pick);
      if (!from_mngr_val && mngr_src_q.size() > 0 && pick)
      begin
        from_mngr_val  = 1'b1;
        from_mngr_data = mngr_src_q[0];
      end
      // settle and then record what fires at the next rising edge
      #5;
      if (imemreq_val && imemreq_rdy)
      begin
        fetch_word(imemreq_addr, imemresp_data_next);
        iresp_q.push_back(imemresp_data_next);
      end
      if (imemresp_val && imemresp_rdy)
      begin
        void'(iresp_q.pop_front());
        imem_taken = 1'b1;
      end
      if (dmemreq_val && dmemreq_rdy)
        serve_data_req();
      if (dmemresp_val && dmemresp_rdy)
      begin
        void'(dresp_q.pop_front());
        dmem_taken = 1'b1;
      end
      if (from_mngr_val && from_mngr_rdy)
      begin
        void'(mngr_src_q.pop_front());
        mngr_taken = 1'b1;
      end
      if (to_mngr_val && to_mngr_rdy)
        take_output();
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      report_counts();
      $display("Testbench failed");
      $finish;
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    imemreq_rdy    = 1'b0;
    imemresp_val   = 1'b0;
    imemresp_data  = 32'd0;
    dmemreq_rdy    = 1'b0;
    dmemresp_val   = 1'b0;
    dmemresp_data  = 32'd0;
    from_mngr_val  = 1'b0;
    from_mngr_data = 32'd0;
    to_mngr_rdy    = 1'b0;
    {imem_taken, dmem_taken, mngr_taken} = 3'b000;
    err_cnt   = 0;
    recv_cnt  = 0;
    dreq_cnt  = 0;
    cycle_cnt = 0;
    lfsr      = 32'h9a19_2ff9;
    load_program();
    repeat (4) @(negedge clk);
    rst_n <= 1'b1;
    check_value("stats_en", 32'(stats_en), 32'd0);
    for (row_idx = 0; row_idx < num_rows; row_idx++)
    begin
      queue_row(row_idx);
      while (recv_cnt < (row_idx + 1) * words_per_row)
        @(posedge clk);
    end
    // last csrw reaches W a few cycles after the final word
    @(negedge clk);
    settle = 0;
    while (settle < 32 && stats_en != test_rows[num_rows - 1][64])
    begin
      @(negedge clk);
      settle++;
    end
    check_value("stats_en", 32'(stats_en), 32'(test_rows[num_rows - 1][64]));
    // a wrong-path mtx would surface in this idle window
    repeat (40) @(negedge clk);
    if (recv_cnt != num_rows * words_per_row || expect_q.size() != 0)
    begin
      $display("word count off, %0d words received", recv_cnt);
      err_cnt++;
    end
    report_counts();
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: compile.f
proc_inst_pkg.sv
proc_mem_pkg.sv
proc_regfile.sv
proc_csr.sv
proc_ctrl.sv
proc_dpath.sv
proc_pipelined.sv
tb_proc.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_proc
FILELIST  := compile.f
OBJ_DIR   := obj_dir
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
